// File: common/synctimer_config.svh
`ifndef SYNCTIMER_CONFIG_SVH
`define SYNCTIMER_CONFIG_SVH

// width of the time-of-day value in ns
`define SYNCTIMER_TIMER_WIDTH 64

// clock period in ns as NUMERATOR / DENOMINATOR
`define SYNCTIMER_NUMERATOR   10
`define SYNCTIMER_DENOMINATOR 3

// signed offsets, limits and pending step count
`define SYNCTIMER_ERROR_WIDTH 32

// drift is divided by 2**GAIN before it is applied
`define SYNCTIMER_PERIOD_GAIN 2

`endif

// File: common/wb_pkg.sv
package wb_pkg;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr; // word address
        logic [31:0] dat;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    localparam logic [2:0] WB_ADR_SET_LO     = 3'd0;
    localparam logic [2:0] WB_ADR_SET_HI     = 3'd1; // write loads the timer
    localparam logic [2:0] WB_ADR_TIME_LO    = 3'd2; // read snapshots the high word
    localparam logic [2:0] WB_ADR_TIME_HI    = 3'd3;
    localparam logic [2:0] WB_ADR_PHASE_MIN  = 3'd4;
    localparam logic [2:0] WB_ADR_PHASE_MAX  = 3'd5;
    localparam logic [2:0] WB_ADR_PERIOD_MIN = 3'd6;
    localparam logic [2:0] WB_ADR_PERIOD_MAX = 3'd7;

endpackage

// File: common/synctimer_pkg.sv
package synctimer_pkg;

`include "synctimer_config.svh"

    typedef logic [`SYNCTIMER_TIMER_WIDTH-1:0]        time_t;
    typedef logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] error_t; // reference minus local

    // sample from the reference clock
    typedef struct packed {
        logic  valid;
        logic  override; // load instead of steering
        time_t time_value;
    } correct_t;

    typedef struct packed {
        logic   valid;
        error_t value;
    } estimate_t;

    typedef struct packed {
        logic  valid;
        time_t time_value;
    } set_req_t;

    typedef struct packed {
        error_t phase_min;
        error_t phase_max;
        error_t period_min;
        error_t period_max;
    } limits_t;

endpackage

// File: src/synctimer_timer.sv
`timescale 1ns/1ps
`include "synctimer_config.svh"

module synctimer_timer (
    input  logic                    clk,
    input  logic                    reset,
    input  synctimer_pkg::set_req_t set,
    input  logic                    adjust_sign,
    input  logic                    adjust_valid,
    output logic                    adjust_ready,
    output synctimer_pkg::time_t    current_time
);
    import synctimer_pkg::*;

    localparam int unsigned INT_STEP   = `SYNCTIMER_NUMERATOR / `SYNCTIMER_DENOMINATOR;
    localparam int unsigned FRAC_STEP  = `SYNCTIMER_NUMERATOR % `SYNCTIMER_DENOMINATOR;
    localparam int unsigned FRAC_WIDTH = $clog2(2 * `SYNCTIMER_DENOMINATOR);
    localparam logic [FRAC_WIDTH-1:0] FRAC_MOD = FRAC_WIDTH'(`SYNCTIMER_DENOMINATOR);

    logic [FRAC_WIDTH-1:0] frac;      // remainder in units of 1/DENOMINATOR ns
    logic [FRAC_WIDTH-1:0] frac_sum;
    logic [FRAC_WIDTH-1:0] frac_next;
    logic                  carry;
    time_t                 step;

    assign adjust_ready = !set.valid; // a load swallows the step

    always_comb begin
        frac_sum  = frac + FRAC_WIDTH'(FRAC_STEP);
        carry     = frac_sum >= FRAC_MOD;
        frac_next = carry ? frac_sum - FRAC_MOD : frac_sum;
        step      = time_t'(INT_STEP) + time_t'(carry);
        if (adjust_valid && adjust_ready) begin
            if (adjust_sign) begin
                step = step - time_t'(1); // slow down by 1 ns
            end else begin
                step = step + time_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current_time <= '0;
            frac         <= '0;
        end else if (set.valid) begin
            current_time <= set.time_value;
            frac         <= '0; // rate restarts from the load
        end else begin
            current_time <= current_time + step;
            frac         <= frac_next;
        end
    end

endmodule

// File: adjust/synctimer_phase_est.sv
`timescale 1ns/1ps
`include "synctimer_config.svh"

module synctimer_phase_est (
    input  logic                     clk,
    input  logic                     reset,
    input  synctimer_pkg::correct_t  sample,
    input  synctimer_pkg::time_t     current_time,
    input  synctimer_pkg::limits_t   limits,
    output synctimer_pkg::estimate_t phase
);
    import synctimer_pkg::*;

    time_t  diff;
    error_t offset;
    error_t clamped;
    logic   phase_valid;
    error_t phase_value;

    // offset wraps like the timer so only the low bits matter
    always_comb begin
        diff    = sample.time_value - current_time;
        offset  = diff[`SYNCTIMER_ERROR_WIDTH-1:0];
        clamped = offset;
        if (offset < limits.phase_min) begin
            clamped = limits.phase_min;
        end else if (offset > limits.phase_max) begin
            clamped = limits.phase_max;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_valid <= 1'b0;
        end else begin
            phase_valid <= sample.valid; // one cycle per sample
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid) begin
            phase_value <= clamped;
        end
    end

    assign phase = '{valid: phase_valid, value: phase_value};

endmodule

// File: adjust/synctimer_period_est.sv
`timescale 1ns/1ps
`include "synctimer_config.svh"

module synctimer_period_est (
    input  logic                     clk,
    input  logic                     reset,
    input  synctimer_pkg::correct_t  sample,
    input  synctimer_pkg::time_t     current_time,
    input  synctimer_pkg::limits_t   limits,
    input  logic                     flush,
    output synctimer_pkg::estimate_t period
);
    import synctimer_pkg::*;

    time_t  diff;
    error_t offset;
    error_t prev_offset; // raw offset of the last sample
    error_t drift;
    error_t clamped;
    logic   have_prev;
    logic   period_valid;
    error_t period_value;

    always_comb begin
        diff    = sample.time_value - current_time;
        offset  = diff[`SYNCTIMER_ERROR_WIDTH-1:0];
        drift   = offset - prev_offset;
        clamped = drift;
        if (drift < limits.period_min) begin
            clamped = limits.period_min;
        end else if (drift > limits.period_max) begin
            clamped = limits.period_max;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            have_prev <= 1'b0; // next sample only primes
        end else if (sample.valid) begin
            have_prev <= 1'b1;
        end
        if (reset) begin
            period_valid <= 1'b0;
        end else begin
            period_valid <= sample.valid && have_prev && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (sample.valid) begin
            prev_offset  <= offset;
            period_value <= clamped >>> `SYNCTIMER_PERIOD_GAIN;
        end
    end

    assign period = '{valid: period_valid, value: period_value};

endmodule

// File: adjust/synctimer_adjust.sv
`timescale 1ns/1ps

module synctimer_adjust (
    input  logic                    clk,
    input  logic                    reset,
    input  synctimer_pkg::correct_t correct,
    input  synctimer_pkg::set_req_t reg_set,
    input  synctimer_pkg::time_t    current_time,
    input  synctimer_pkg::limits_t  limits,
    output synctimer_pkg::set_req_t timer_set,
    output logic                    adjust_sign,
    output logic                    adjust_valid,
    input  logic                    adjust_ready
);
    import synctimer_pkg::*;

    correct_t  est_sample; // normal samples only
    estimate_t phase;
    estimate_t period;
    error_t    pending;    // signed steps still owed to the timer
    error_t    pending_next;

    // register write wins over an override sample
    always_comb begin
        timer_set.valid      = 1'b0;
        timer_set.time_value = correct.time_value;
        if (reg_set.valid) begin
            timer_set = reg_set;
        end else if (correct.valid && correct.override) begin
            timer_set.valid = 1'b1;
        end
        est_sample       = correct;
        est_sample.valid = correct.valid && !timer_set.valid;
    end

    synctimer_phase_est u_phase_est (
        .clk          (clk),
        .reset        (reset),
        .sample       (est_sample),
        .current_time (current_time),
        .limits       (limits),
        .phase        (phase)
    );

    synctimer_period_est u_period_est (
        .clk          (clk),
        .reset        (reset),
        .sample       (est_sample),
        .current_time (current_time),
        .limits       (limits),
        .flush        (timer_set.valid), // drift across a load is meaningless
        .period       (period)
    );

    assign adjust_valid = pending != '0;
    assign adjust_sign  = pending[$bits(error_t)-1]; // negative means step back

    always_comb begin
        pending_next = pending;
        if (phase.valid) begin
            pending_next = pending_next + phase.value;
        end
        if (period.valid) begin
            pending_next = pending_next + period.value;
        end
        if (adjust_valid && adjust_ready) begin
            if (adjust_sign) begin
                pending_next = pending_next + error_t'(1);
            end else begin
                pending_next = pending_next - error_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || timer_set.valid) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

endmodule

// File: src/synctimer_regs.sv
`timescale 1ns/1ps

module synctimer_regs (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_pkg::wb_req_t         wb_req,
    output wb_pkg::wb_rsp_t         wb_rsp,
    input  synctimer_pkg::time_t    current_time,
    output synctimer_pkg::set_req_t reg_set,
    output synctimer_pkg::limits_t  limits
);
    import wb_pkg::*;
    import synctimer_pkg::*;

    logic        access; // new request, not yet acked
    logic        ack;
    logic [31:0] rd_dat;
    logic [31:0] rd_word;
    logic [31:0] set_lo;
    logic [31:0] set_hi;
    logic [31:0] time_hi_shadow;
    logic        set_valid;
    time_t       set_time;

    function automatic logic [31:0] byte_merge(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0]  sel);
        logic [31:0] result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    assign access = wb_req.cyc && wb_req.stb && !ack;

    always_comb begin
        case (wb_req.adr)
            WB_ADR_SET_LO:     rd_word = set_lo;
            WB_ADR_SET_HI:     rd_word = set_hi;
            WB_ADR_TIME_LO:    rd_word = current_time[31:0];
            WB_ADR_TIME_HI:    rd_word = time_hi_shadow;
            WB_ADR_PHASE_MIN:  rd_word = limits.phase_min;
            WB_ADR_PHASE_MAX:  rd_word = limits.phase_max;
            WB_ADR_PERIOD_MIN: rd_word = limits.period_min;
            default:           rd_word = limits.period_max;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ack               <= 1'b0;
            set_valid         <= 1'b0;
            limits.phase_min  <= error_t'(-1000);
            limits.phase_max  <= error_t'(1000);
            limits.period_min <= error_t'(-100);
            limits.period_max <= error_t'(100);
        end else begin
            ack       <= access;
            set_valid <= access && wb_req.we && wb_req.adr == WB_ADR_SET_HI;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    WB_ADR_PHASE_MIN:
                        limits.phase_min <= byte_merge(limits.phase_min, wb_req.dat, wb_req.sel);
                    WB_ADR_PHASE_MAX:
                        limits.phase_max <= byte_merge(limits.phase_max, wb_req.dat, wb_req.sel);
                    WB_ADR_PERIOD_MIN:
                        limits.period_min <= byte_merge(limits.period_min, wb_req.dat,
                                                        wb_req.sel);
                    WB_ADR_PERIOD_MAX:
                        limits.period_max <= byte_merge(limits.period_max, wb_req.dat,
                                                        wb_req.sel);
                    default: ; // set and time words handled below
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rd_dat <= rd_word;
            if (wb_req.we && wb_req.adr == WB_ADR_SET_LO) begin
                set_lo <= byte_merge(set_lo, wb_req.dat, wb_req.sel);
            end
            if (wb_req.we && wb_req.adr == WB_ADR_SET_HI) begin
                set_hi   <= byte_merge(set_hi, wb_req.dat, wb_req.sel);
                set_time <= {byte_merge(set_hi, wb_req.dat, wb_req.sel), set_lo};
            end
            if (!wb_req.we && wb_req.adr == WB_ADR_TIME_LO) begin
                time_hi_shadow <= current_time[63:32]; // keeps lo/hi consistent
            end
        end
    end

    assign wb_rsp  = '{ack: ack, dat: rd_dat};
    assign reg_set = '{valid: set_valid, time_value: set_time};

endmodule

// File: src/synctimer_top.sv
`timescale 1ns/1ps

module synctimer_top (
    input  logic                    clk,
    input  logic                    reset,
    input  wb_pkg::wb_req_t         wb_req,
    output wb_pkg::wb_rsp_t         wb_rsp,
    input  synctimer_pkg::correct_t correct,
    output synctimer_pkg::time_t    current_time
);
    import synctimer_pkg::*;

    set_req_t reg_set;   // host load pulse
    set_req_t timer_set; // selected load
    limits_t  limits;
    logic     adjust_sign;
    logic     adjust_valid;
    logic     adjust_ready;

    synctimer_regs u_synctimer_regs (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .current_time (current_time),
        .reg_set      (reg_set),
        .limits       (limits)
    );

    synctimer_adjust u_synctimer_adjust (
        .clk          (clk),
        .reset        (reset),
        .correct      (correct),
        .reg_set      (reg_set),
        .current_time (current_time),
        .limits       (limits),
        .timer_set    (timer_set),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready)
    );

    synctimer_timer u_synctimer_timer (
        .clk          (clk),
        .reset        (reset),
        .set          (timer_set),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready),
        .current_time (current_time)
    );

endmodule

// File: dv/synctimer_assert.sv
`timescale 1ns/1ps

module synctimer_assert (
    input logic                    clk,
    input logic                    reset,
    input wb_pkg::wb_req_t         wb_req,
    input wb_pkg::wb_rsp_t         wb_rsp,
    input synctimer_pkg::set_req_t reg_set,
    input synctimer_pkg::set_req_t timer_set,
    input logic                    adjust_valid,
    input logic                    adjust_ready
);

    // ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("wb ack held longer than one cycle");

    ack_needs_request: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)) // request sampled one clock earlier
        else $error("wb ack without a cyc/stb request");

    // a step request stalled by a load is cancelled with it
    adjust_cancelled: assert property (@(posedge clk) disable iff (reset)
        adjust_valid && !adjust_ready |=> !adjust_valid)
        else $error("step request survived the load that stalled it");

    reset_idle: assert property (@(posedge clk)
        reset |=> !wb_rsp.ack && !reg_set.valid && !adjust_valid)
        else $error("valid or ack high right after reset");

endmodule

bind synctimer_top synctimer_assert assert_i (
    .clk          (clk),
    .reset        (reset),
    .wb_req       (wb_req),
    .wb_rsp       (wb_rsp),
    .reg_set      (reg_set),
    .timer_set    (timer_set),
    .adjust_valid (adjust_valid),
    .adjust_ready (adjust_ready)
);

// File: dv/synctimer_tb.sv
`timescale 1ns/1ps
`include "synctimer_config.svh"

module synctimer_tb;
    import synctimer_pkg::*;
    import wb_pkg::*;

    typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_CORRECT, OP_OVERRIDE, OP_IDLE} op_e;

    // data is write data, load time or idle cycles
    typedef struct packed {
        op_e         op;
        logic [2:0]  adr;
        logic [63:0] data;
        logic [63:0] exp;
    } row_t;

    logic      clk;
    logic      reset;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;
    correct_t  correct;
    time_t     current_time;

    row_t        rows[$];
    logic [15:0] lfsr = 16'd41;
    int          cycles = 0;
    int          limit;
    int          max_row;

    // reference model state
    time_t       m_time;
    int          m_frac;
    error_t      m_pending;
    logic        m_ack;
    logic        m_set;
    time_t       m_set_time;
    logic [31:0] m_set_lo;
    logic [31:0] m_rd_lo;
    logic [31:0] m_shadow;
    limits_t     m_limits;
    estimate_t   m_phase;
    estimate_t   m_period;
    error_t      m_prev;
    logic        m_have_prev;

    synctimer_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .correct      (correct),
        .current_time (current_time)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? (s >> 1) ^ 16'hb400 : s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_step(lfsr);
            value = value * 2 + int'(lfsr[0]);
        end
    endtask

    function automatic error_t clamp(input error_t value, input error_t lo, input error_t hi);
        if (value < lo) begin
            return lo;
        end
        if (value > hi) begin
            return hi;
        end
        return value;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
            $display("test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    always @(posedge clk) begin : ref_model
        logic   access;
        logic   load;
        logic   sample;
        time_t  diff;
        error_t offset;
        int     frac;
        int     carry;
        int     dir;
        access = wb_req.cyc && wb_req.stb && !m_ack;
        if (reset) begin
            m_ack             <= 1'b0;
            m_set             <= 1'b0;
            m_time            <= '0;
            m_frac            <= 0;
            m_pending         <= '0;
            m_phase.valid     <= 1'b0;
            m_period.valid    <= 1'b0;
            m_have_prev       <= 1'b0;
            m_limits          <= '{-1000, 1000, -100, 100};
        end else begin
            m_ack <= access;
            m_set <= access && wb_req.we && wb_req.adr == WB_ADR_SET_HI;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    WB_ADR_SET_LO:     m_set_lo <= wb_req.dat;
                    WB_ADR_SET_HI:     m_set_time <= {wb_req.dat, m_set_lo};
                    WB_ADR_PHASE_MIN:  m_limits.phase_min <= wb_req.dat;
                    WB_ADR_PHASE_MAX:  m_limits.phase_max <= wb_req.dat;
                    WB_ADR_PERIOD_MIN: m_limits.period_min <= wb_req.dat;
                    WB_ADR_PERIOD_MAX: m_limits.period_max <= wb_req.dat;
                    default: ;
                endcase
            end
            if (access && !wb_req.we && wb_req.adr == WB_ADR_TIME_LO) begin
                m_rd_lo  <= m_time[31:0];
                m_shadow <= m_time[63:32];
            end
            load   = m_set || (correct.valid && correct.override); // host load first
            sample = correct.valid && !load;
            diff   = correct.time_value - m_time;
            offset = diff[31:0];
            frac   = m_frac + `SYNCTIMER_NUMERATOR % `SYNCTIMER_DENOMINATOR;
            carry  = frac >= `SYNCTIMER_DENOMINATOR ? 1 : 0;
            dir    = m_pending > 0 ? 1 : (m_pending < 0 ? -1 : 0);
            if (load) begin
                m_time      <= m_set ? m_set_time : correct.time_value;
                m_frac      <= 0;
                m_pending   <= '0;
                m_have_prev <= 1'b0;
            end else begin
                m_time    <= m_time + 64'(`SYNCTIMER_NUMERATOR / `SYNCTIMER_DENOMINATOR
                                          + carry + dir);
                m_frac    <= frac - carry * `SYNCTIMER_DENOMINATOR;
                m_pending <= m_pending - dir + (m_phase.valid ? m_phase.value : 0)
                             + (m_period.valid ? m_period.value : 0);
            end
            m_phase.valid  <= sample;
            m_period.valid <= sample && m_have_prev;
            if (sample) begin
                m_phase.value  <= clamp(offset, m_limits.phase_min, m_limits.phase_max);
                m_period.value <= clamp(offset - m_prev, m_limits.period_min,
                                        m_limits.period_max) >>> `SYNCTIMER_PERIOD_GAIN;
                m_prev         <= offset;
                m_have_prev    <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > limit) begin
            $display("timeout: the run went past %0d clock cycles", limit);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdata);
        int waited;
        waited = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: 4'hf};
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_rsp.ack);
        rdata  = wb_rsp.dat;
        wb_req = '0; // master drops the request on ack
        check_value("ack latency", 64'd1, 64'(waited));
        @(negedge clk);
        check_value("wb_rsp.ack", 64'd0, 64'(wb_rsp.ack));
    endtask

    task automatic send_sample(input logic override, input time_t value);
        correct = '{valid: 1'b1, override: override, time_value: value};
        @(negedge clk);
        correct = '0;
    endtask

    task automatic add_row(input op_e op, input logic [2:0] adr, input logic [63:0] data,
                           input logic [63:0] exp);
        rows.push_back('{op: op, adr: adr, data: data, exp: exp});
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] rdata;
        logic [63:0] expected;
        int          bits;
        int          offset;
        case (r.op)
            OP_WRITE: begin
                wb_access(1'b1, r.adr, r.data[31:0], rdata);
            end
            OP_READ: begin
                wb_access(1'b0, r.adr, 32'd0, rdata);
                expected = r.exp;
                if (r.adr == WB_ADR_TIME_LO) begin
                    expected = {32'd0, m_rd_lo}; // value at the sampling edge
                end else if (r.adr == WB_ADR_TIME_HI) begin
                    expected = {32'd0, m_shadow};
                end
                check_value("wb_rsp.dat", expected, {32'd0, rdata});
            end
            OP_CORRECT: begin
                take_bits(12, bits);
                offset = bits % 4001 - 2000; // within +-2000
                send_sample(1'b0, m_time + 64'(offset));
            end
            OP_OVERRIDE: begin
                send_sample(1'b1, r.data);
                check_value("current_time", r.data, current_time);
            end
            default: begin
                repeat (int'(r.data)) @(negedge clk);
                if (r.exp != '0) begin
                    check_value("current_time", r.exp, current_time);
                end
            end
        endcase
    endtask

    initial begin
        reset   = 1'b1;
        wb_req  = '0;
        correct = '0;
        add_row(OP_IDLE,     3'd0,              64'd9,              64'd30); // 10*9/3
        add_row(OP_READ,     WB_ADR_PERIOD_MAX, 64'd0,              64'd100);
        add_row(OP_READ,     WB_ADR_PHASE_MIN,  64'd0,              64'hffff_fc18);
        add_row(OP_WRITE,    WB_ADR_SET_LO,     64'hffff_fffb,      64'd0);
        add_row(OP_WRITE,    WB_ADR_SET_HI,     64'h12,             64'd0);
        add_row(OP_IDLE,     3'd0,              64'd0,              64'h12_ffff_fffb);
        add_row(OP_READ,     WB_ADR_TIME_LO,    64'd0,              64'd0);
        add_row(OP_READ,     WB_ADR_TIME_HI,    64'd0,              64'd0);
        add_row(OP_IDLE,     3'd0,              64'd3,              64'd0);
        add_row(OP_READ,     WB_ADR_TIME_LO,    64'd0,              64'd0);
        add_row(OP_READ,     WB_ADR_TIME_HI,    64'd0,              64'd0); // past the wrap
        add_row(OP_WRITE,    WB_ADR_PHASE_MIN,  64'hffff_fce0,      64'd0);
        add_row(OP_WRITE,    WB_ADR_PHASE_MAX,  64'd800,            64'd0);
        add_row(OP_WRITE,    WB_ADR_PERIOD_MIN, 64'hffff_ffc4,      64'd0);
        add_row(OP_WRITE,    WB_ADR_PERIOD_MAX, 64'd60,             64'd0);
        add_row(OP_READ,     WB_ADR_PHASE_MIN,  64'd0,              64'hffff_fce0);
        add_row(OP_READ,     WB_ADR_PHASE_MAX,  64'd0,              64'd800);
        add_row(OP_READ,     WB_ADR_PERIOD_MIN, 64'd0,              64'hffff_ffc4);
        add_row(OP_READ,     WB_ADR_PERIOD_MAX, 64'd0,              64'd60);
        add_row(OP_CORRECT,  3'd0,              64'd0,              64'd0);
        add_row(OP_IDLE,     3'd0,              64'd3,              64'd0);
        add_row(OP_OVERRIDE, 3'd0,              64'h100_0000_0000,  64'd0); // mid drain
        add_row(OP_IDLE,     3'd0,              64'd2,              64'd0);
        add_row(OP_CORRECT,  3'd0,              64'd0,              64'd0); // primes period
        add_row(OP_IDLE,     3'd0,              64'd1200,           64'd0);
        add_row(OP_CORRECT,  3'd0,              64'd0,              64'd0);
        add_row(OP_IDLE,     3'd0,              64'd1200,           64'd0);
        add_row(OP_CORRECT,  3'd0,              64'd0,              64'd0);
        add_row(OP_IDLE,     3'd0,              64'd1200,           64'd0);
        max_row = 4; // longest bus access
        foreach (rows[i]) begin
            if (rows[i].op == OP_IDLE && int'(rows[i].data) > max_row) begin
                max_row = int'(rows[i].data);
            end
        end
        limit = rows.size() * max_row + 8 + 64;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        foreach (rows[i]) begin
            apply_row(rows[i]);
            check_value("current_time", m_time, current_time);
            check_value("pending", 64'(m_pending), 64'(dut_i.u_synctimer_adjust.pending));
        end
        $display("test passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+common
common/wb_pkg.sv
common/synctimer_pkg.sv
src/synctimer_timer.sv
adjust/synctimer_phase_est.sv
adjust/synctimer_period_est.sv
adjust/synctimer_adjust.sv
src/synctimer_regs.sv
src/synctimer_top.sv
dv/synctimer_assert.sv
dv/synctimer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= synctimer_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
